/* pcap_replay.f */
replay_cfg_pkg.sv
replay_axis_pkg.sv
replay_width_gather.sv
replay_fifo.sv
replay_deframer.sv
replay_engine.sv
tb_clock_gen.sv
replay_engine_chk.sv
tb_replay_engine.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the replay engine testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_replay_engine \
  -f pcap_replay.f --Mdir "$build_dir"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/Vtb_replay_engine" +verilator+error+limit+1000 > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$log_file"; then
  exit 1
fi
exit 0

/* tb_replay_engine.sv */
// Replay engine testbench with record builder, reference beats, scoreboard and watchdog
`timescale 1ns/1ps

module tb_replay_engine;

  typedef struct packed {
    replay_axis_pkg::tdata_t tdata;
    replay_axis_pkg::tstrb_t tstrb;
    replay_axis_pkg::tuser_t tuser;
    logic                    tlast;
  } beat_t;

  typedef logic [7:0] byte_q_t [$];

  logic                     axi_aclk;
  logic                     rst;
  logic                     sw_rst;
  logic                     fifo_wr_en;
  replay_cfg_pkg::wr_word_t fifo_din;
  logic                     fifo_full;
  logic                     fifo_prog_full;
  replay_axis_pkg::tdata_t  m_axis_tdata;
  replay_axis_pkg::tstrb_t  m_axis_tstrb;
  replay_axis_pkg::tuser_t  m_axis_tuser;
  logic                     m_axis_tvalid;
  logic                     m_axis_tready;
  logic                     m_axis_tlast;

  int    seed = 32'h52ee41ad;
  // 0 holds tready low, 1 high, 2 random
  int    ready_mode = 0;
  int    words_total = 0;
  int    beats_checked = 0;
  int    value_errors = 0;
  int    other_errors = 0;
  string test_name = "startup";
  beat_t exp_q [$];
  replay_cfg_pkg::wr_word_t wr_q [$];

  tb_clock_gen #(.PERIOD_NS(100.0)) tb_clock_gen_i (.clk(axi_aclk));

  replay_engine replay_engine_i (.*);

  task automatic check_value(input string name, input logic [71:0] exp_val,
                             input logic [71:0] act_val);
    if (exp_val !== act_val) begin
      value_errors++;
      $display("error %s %s: expected %0h, actual %0h", test_name, name, exp_val, act_val);
    end
  endtask

  task automatic note_failure(input string msg);
    other_errors++;
    $display("%s: %s", test_name, msg);
  endtask

  // Expected beat from the byte list with lane 0 first
  function automatic beat_t ref_beat(input byte_q_t bytes, input logic [31:0] tuser,
                                     input int beat_idx);
    beat_t beat;
    int    pos;
    beat = '0;
    beat.tuser = tuser;
    for (int lane = 0; lane < 8; lane++) begin
      pos = beat_idx * 8 + lane;
      if (pos < bytes.size()) begin
        beat.tdata[lane*8 +: 8] = bytes[pos];
        beat.tstrb[lane] = 1'b1;
      end
    end
    // First beat short of a full strobe closes the packet
    beat.tlast = (beat.tstrb != 8'hff);
    return beat;
  endfunction

  // Header lanes, then one lane per byte, then zero lanes up to a word boundary
  task automatic build_record(input logic [31:0] tuser, input int len, input bit expect_beats);
    byte_q_t    bytes;
    logic [8:0] lanes [$];
    beat_t      beat;
    int         b;
    for (int i = 0; i < 8; i++) begin
      lanes.push_back((i < 4) ? {1'b1, tuser[8*i +: 8]} : 9'h000);
    end
    for (int i = 0; i < len; i++) begin
      bytes.push_back(8'($random(seed)));
      lanes.push_back({1'b1, bytes[i]});
    end
    // Whole zero word when len is a multiple of 8
    do begin
      lanes.push_back(9'h000);
    end while (lanes.size() % 8 != 0);
    for (int i = 0; i < lanes.size(); i += 4) begin
      wr_q.push_back({lanes[i+3], lanes[i+2], lanes[i+1], lanes[i]});
      words_total++;
    end
    b = 0;
    while (expect_beats) begin
      beat = ref_beat(bytes, tuser, b);
      exp_q.push_back(beat);
      b++;
      expect_beats = !beat.tlast;
    end
  endtask

  // Host writes pause while fifo_full is high
  task automatic send_words();
    while (wr_q.size() != 0) begin
      @(negedge axi_aclk);
      fifo_wr_en = !fifo_full;
      if (!fifo_full) begin
        fifo_din = wr_q.pop_front();
      end
    end
    @(negedge axi_aclk);
    fifo_wr_en = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge axi_aclk);
    end
    @(negedge axi_aclk);
  endtask

  // Sink side ready
  initial begin
    m_axis_tready = 1'b0;
    forever begin
      @(negedge axi_aclk);
      if (ready_mode == 2) begin
        m_axis_tready = (($random(seed) & 3) != 0);
      end else begin
        m_axis_tready = (ready_mode == 1);
      end
    end
  end

  // Compare every completed beat in order
  always @(posedge axi_aclk) begin : scoreboard
    beat_t exp_beat;
    if (!rst && m_axis_tvalid && m_axis_tready) begin
      if (exp_q.size() == 0) begin
        note_failure("stream delivered a beat that no packet accounts for");
      end else begin
        exp_beat = exp_q.pop_front();
        check_value("tdata", exp_beat.tdata, m_axis_tdata);
        check_value("tstrb", exp_beat.tstrb, m_axis_tstrb);
        check_value("tuser", exp_beat.tuser, m_axis_tuser);
        check_value("tlast", exp_beat.tlast, m_axis_tlast);
        beats_checked++;
      end
    end
  end

  // Limit grows with every word queued
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= words_total * 20 + 200) begin
      @(posedge axi_aclk);
      cycles++;
    end
    $display("Timeout in %s after %0d cycles", test_name, cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : main
    int beats_before;
    int len;
    int fails;
    rst = 1'b1;
    sw_rst = 1'b0;
    fifo_wr_en = 1'b0;
    fifo_din = '0;
    repeat (2) @(negedge axi_aclk);
    rst = 1'b0;
    @(negedge axi_aclk);
    test_name = "reset";
    check_value("tvalid", 0, m_axis_tvalid);
    check_value("tlast", 0, m_axis_tlast);
    check_value("fifo_full", 0, fifo_full);
    check_value("fifo_prog_full", 0, fifo_prog_full);
    check_value("tuser", 0, m_axis_tuser);

    test_name = "single_13_bytes";
    ready_mode = 1;
    beats_before = beats_checked;
    build_record(32'h1357_9bdf, 13, 1'b1);
    send_words();
    wait_drain();
    check_value("beat count", 2, beats_checked - beats_before);

    // Packet 3 always a multiple of 8 bytes
    test_name = "back_to_back";
    for (int i = 0; i < 8; i++) begin
      len = (i == 3) ? 8 * (1 + $unsigned($random(seed)) % 5) : 1 + $unsigned($random(seed)) % 40;
      build_record(32'($random(seed)), len, 1'b1);
    end
    send_words();
    wait_drain();

    test_name = "random_ready";
    for (int i = 0; i < 8; i++) begin
      build_record(32'($random(seed)), 1 + $unsigned($random(seed)) % 40, 1'b1);
    end
    ready_mode = 2;
    send_words();
    wait_drain();
    ready_mode = 1;
    @(negedge axi_aclk);

    // FIFO fills until full behind a stalled sink
    test_name = "fill_then_drain";
    ready_mode = 0;
    for (int i = 0; i < 5; i++) begin
      build_record(32'($random(seed)), 40, 1'b1);
    end
    fork
      send_words();
      begin
        while (!fifo_prog_full) begin
          @(negedge axi_aclk);
        end
        check_value("fifo_full as prog_full rises", 0, fifo_full);
        while (!fifo_full) begin
          @(negedge axi_aclk);
        end
        repeat (4) @(negedge axi_aclk);
        ready_mode = 1;
      end
    join
    wait_drain();
    check_value("fifo_full after drain", 0, fifo_full);
    check_value("fifo_prog_full after drain", 0, fifo_prog_full);

    // Aborted record fills past prog_full and leaves a half word in the gather stage
    test_name = "soft_reset";
    ready_mode = 0;
    build_record(32'hdead_0042, 100, 1'b0);
    void'(wr_q.pop_back());
    send_words();
    repeat (2) @(negedge axi_aclk);
    check_value("tvalid before soft reset", 1, m_axis_tvalid);
    check_value("fifo_prog_full before soft reset", 1, fifo_prog_full);
    sw_rst = 1'b1;
    @(negedge axi_aclk);
    sw_rst = 1'b0;
    repeat (2) @(negedge axi_aclk);
    check_value("tvalid after flush", 0, m_axis_tvalid);
    check_value("fifo_prog_full after flush", 0, fifo_prog_full);
    check_value("tuser after flush", 0, m_axis_tuser);
    ready_mode = 1;
    build_record(32'h0bad_cafe, 1 + $unsigned($random(seed)) % 40, 1'b1);
    send_words();
    wait_drain();

    fails = replay_engine_i.replay_engine_chk_i.assert_fails;
    $display("Closing counts: %0d value errors, %0d other errors, %0d assert failures, %0d beats",
             value_errors, other_errors, fails, beats_checked);
    if (value_errors + other_errors + fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* replay_engine_chk.sv */
// Stream hold, tlast qualification and FIFO flag ordering assertions, bound to replay_engine
`timescale 1ns/1ps

module replay_engine_chk (
  input logic                    axi_aclk,
  input logic                    rst,
  input logic                    flush,
  input logic                    fifo_full,
  input logic                    fifo_prog_full,
  input replay_axis_pkg::tdata_t m_axis_tdata,
  input replay_axis_pkg::tstrb_t m_axis_tstrb,
  input replay_axis_pkg::tuser_t m_axis_tuser,
  input logic                    m_axis_tvalid,
  input logic                    m_axis_tready,
  input logic                    m_axis_tlast
);

  // Failed assertion tally, read by the testbench at the end
  int assert_fails = 0;

  // Stalled beat keeps every field, flush excepted
  hold_check: assert property (@(posedge axi_aclk) disable iff (rst)
    (m_axis_tvalid && !m_axis_tready && !flush) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tstrb) &&
       $stable(m_axis_tuser) && $stable(m_axis_tlast)))
  else begin
    assert_fails++;
    $error("stream fields changed while stalled");
  end

  // tlast only on a valid beat
  last_check: assert property (@(posedge axi_aclk) disable iff (rst)
    m_axis_tlast |-> m_axis_tvalid)
  else begin
    assert_fails++;
    $error("tlast high without tvalid");
  end

  // Full threshold sits above the almost-full one
  level_check: assert property (@(posedge axi_aclk) disable iff (rst)
    fifo_full |-> fifo_prog_full)
  else begin
    assert_fails++;
    $error("fifo_full high without fifo_prog_full");
  end

endmodule

bind replay_engine replay_engine_chk replay_engine_chk_i (
  .axi_aclk       (axi_aclk),
  .rst            (rst),
  .flush          (flush),
  .fifo_full      (fifo_full),
  .fifo_prog_full (fifo_prog_full),
  .m_axis_tdata   (m_axis_tdata),
  .m_axis_tstrb   (m_axis_tstrb),
  .m_axis_tuser   (m_axis_tuser),
  .m_axis_tvalid  (m_axis_tvalid),
  .m_axis_tready  (m_axis_tready),
  .m_axis_tlast   (m_axis_tlast)
);

/* tb_clock_gen.sv */
// Free-running testbench clock source
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 100.0
) (
  output logic clk
);

  // Starts low, first rising edge half a period in
  initial begin
    clk = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2.0);
    clk = ~clk;
  end

endmodule

/* replay_engine.sv */
// Packet replay top level, gather stage, FIFO and deframer in a chain
`timescale 1ns/1ps

module replay_engine #(
  parameter int FIFO_DEPTH      = replay_cfg_pkg::FIFO_DEPTH_DEFAULT,
  parameter int PROG_FULL_LEVEL = replay_cfg_pkg::PROG_FULL_DEFAULT
) (
  input  logic                         axi_aclk,
  input  logic                         rst,
  input  logic                         sw_rst,
  // Host write side
  input  logic                         fifo_wr_en,
  input  replay_cfg_pkg::wr_word_t     fifo_din,
  output logic                         fifo_full,
  output logic                         fifo_prog_full,
  // Stream master
  output replay_axis_pkg::tdata_t      m_axis_tdata,
  output replay_axis_pkg::tstrb_t      m_axis_tstrb,
  output replay_axis_pkg::tuser_t      m_axis_tuser,
  output logic                         m_axis_tvalid,
  input  logic                         m_axis_tready,
  output logic                         m_axis_tlast
);

  // Gather to FIFO
  logic                         push;
  replay_cfg_pkg::packed_word_t push_word;

  // FIFO to deframer
  logic                         pop;
  replay_cfg_pkg::packed_word_t pop_word;
  logic                         empty;

  // Retimed soft reset, fans out to all stages
  logic                         flush;

  replay_width_gather replay_width_gather_i (
    .axi_aclk   (axi_aclk),
    .rst        (rst),
    .flush      (flush),
    .fifo_wr_en (fifo_wr_en),
    .fifo_din   (fifo_din),
    .push       (push),
    .push_word  (push_word)
  );

  replay_fifo #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .PROG_FULL_LEVEL (PROG_FULL_LEVEL)
  ) replay_fifo_i (
    .axi_aclk  (axi_aclk),
    .rst       (rst),
    .sw_rst    (sw_rst),
    .push      (push),
    .push_word (push_word),
    .pop       (pop),
    .pop_word  (pop_word),
    .empty     (empty),
    .full      (fifo_full),
    .prog_full (fifo_prog_full),
    .flush     (flush)
  );

  replay_deframer replay_deframer_i (
    .axi_aclk      (axi_aclk),
    .rst           (rst),
    .flush         (flush),
    .pop_word      (pop_word),
    .empty         (empty),
    .m_axis_tready (m_axis_tready),
    .pop           (pop),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tstrb  (m_axis_tstrb),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

/* replay_deframer.sv */
// Header capture and packet streaming FSM, FIFO words to AXI-Stream master
`timescale 1ns/1ps

module replay_deframer (
  input  logic                            axi_aclk,
  input  logic                            rst,
  input  logic                            flush,
  input  replay_cfg_pkg::packed_word_t    pop_word,
  input  logic                            empty,
  input  logic                            m_axis_tready,
  output logic                            pop,
  output replay_axis_pkg::tdata_t         m_axis_tdata,
  output replay_axis_pkg::tstrb_t         m_axis_tstrb,
  output replay_axis_pkg::tuser_t         m_axis_tuser,
  output logic                            m_axis_tvalid,
  output logic                            m_axis_tlast
);

  localparam int LB = replay_cfg_pkg::LANE_BITS;
  localparam int BB = replay_cfg_pkg::BYTE_BITS;

  replay_axis_pkg::deframer_state_t state;
  replay_axis_pkg::deframer_state_t state_next;

  // Unpacked head word
  replay_axis_pkg::tdata_t lane_data;
  replay_axis_pkg::tstrb_t lane_strb;

  // Metadata held for the current packet
  replay_axis_pkg::tuser_t tuser_r;

  // Any missing strobe marks the final beat
  logic partial;

  // Split each 9-bit lane into strobe and byte
  for (genvar i = 0; i < replay_cfg_pkg::RD_LANES; i++) begin : g_lane
    assign lane_strb[i]           = pop_word[i*LB + BB];
    assign lane_data[i*BB +: BB]  = pop_word[i*LB +: BB];
  end

  assign partial = !(&lane_strb);

  // Stream fields follow the head word directly
  assign m_axis_tdata = lane_data;
  assign m_axis_tstrb = lane_strb;
  assign m_axis_tuser = tuser_r;

  // tvalid and tlast do not depend on tready, so they hold under back-pressure
  assign m_axis_tvalid = (state == replay_axis_pkg::st_packet) && !empty;
  assign m_axis_tlast  = m_axis_tvalid && partial;

  // Next state and pop
  always_comb begin
    state_next = state;
    pop        = 1'b0;
    case (state)
      replay_axis_pkg::st_header: begin
        // Header is consumed as soon as it shows up
        if (!empty) begin
          pop        = 1'b1;
          state_next = replay_axis_pkg::st_packet;
        end
      end
      replay_axis_pkg::st_packet: begin
        // Pop only on a completed beat
        if (m_axis_tvalid && m_axis_tready) begin
          pop = 1'b1;
          if (partial) begin
            state_next = replay_axis_pkg::st_header;
          end
        end
      end
      default: begin
        state_next = replay_axis_pkg::st_header;
      end
    endcase
  end

  always_ff @(posedge axi_aclk) begin
    if (rst || flush) begin
      state   <= replay_axis_pkg::st_header;
      tuser_r <= '0;
    end else begin
      state <= state_next;
      // Low four data bytes of the header become tuser
      if (state == replay_axis_pkg::st_header && !empty) begin
        tuser_r <= lane_data[replay_axis_pkg::TUSER_BITS-1:0];
      end
    end
  end

endmodule

/* replay_fifo.sv */
// Synchronous FWFT FIFO with full, almost-full and soft-reset flush
`timescale 1ns/1ps

module replay_fifo #(
  parameter int FIFO_DEPTH      = 16,
  parameter int PROG_FULL_LEVEL = 12
) (
  input  logic                         axi_aclk,
  input  logic                         rst,
  input  logic                         sw_rst,
  input  logic                         push,
  input  replay_cfg_pkg::packed_word_t push_word,
  input  logic                         pop,
  output replay_cfg_pkg::packed_word_t pop_word,
  output logic                         empty,
  output logic                         full,
  output logic                         prog_full,
  output logic                         flush
);

  localparam int PTR_BITS = $clog2(FIFO_DEPTH);
  localparam int CNT_BITS = PTR_BITS + 1;

  // Threshold values at counter width
  localparam logic [CNT_BITS-1:0] CNT_MAX  = CNT_BITS'(FIFO_DEPTH);
  localparam logic [CNT_BITS-1:0] CNT_HIGH = CNT_BITS'(FIFO_DEPTH - 1);
  localparam logic [CNT_BITS-1:0] CNT_PROG = CNT_BITS'(PROG_FULL_LEVEL);

  // Storage
  replay_cfg_pkg::packed_word_t mem [FIFO_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic [CNT_BITS-1:0] count_next;

  // Qualified requests
  logic push_ok;
  logic pop_ok;

  // Head word is always presented, valid while not empty
  assign pop_word = mem[rd_ptr];
  assign empty    = (count == '0);

  // Overflow and underflow guards
  assign push_ok = push && (count != CNT_MAX);
  assign pop_ok  = pop && !empty;

  always_comb begin
    count_next = count + CNT_BITS'(push_ok) - CNT_BITS'(pop_ok);
  end

  // Soft reset is retimed once, then clears every stage
  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      flush <= 1'b0;
    end else begin
      flush <= sw_rst;
    end
  end

  // Pointers, occupancy and level flags
  always_ff @(posedge axi_aclk) begin
    if (rst || flush) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      full      <= 1'b0;
      prog_full <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_next;
      // One slot held back for the word still in the gather stage
      full      <= (count_next >= CNT_HIGH);
      prog_full <= (count_next >= CNT_PROG);
    end
  end

  // Write port
  always_ff @(posedge axi_aclk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_word;
    end
  end

endmodule

/* replay_width_gather.sv */
// Write word pairing stage, two 36-bit host words into one 72-bit packed word
`timescale 1ns/1ps

module replay_width_gather (
  input  logic                        axi_aclk,
  input  logic                        rst,
  input  logic                        flush,
  input  logic                        fifo_wr_en,
  input  replay_cfg_pkg::wr_word_t    fifo_din,
  output logic                        push,
  output replay_cfg_pkg::packed_word_t push_word
);

  // Low half of the word being assembled
  replay_cfg_pkg::wr_word_t half_word;

  // Low when the next write is the first of a pair
  logic phase;

  // Second write of a pair completes the word
  logic pair_done;

  assign pair_done = fifo_wr_en && phase;

  // Control path
  always_ff @(posedge axi_aclk) begin
    if (rst || flush) begin
      phase <= 1'b0;
      push  <= 1'b0;
    end else begin
      // Push pulses one cycle after the completing write
      push <= pair_done;
      if (fifo_wr_en) begin
        phase <= ~phase;
      end
    end
  end

  // Payload path
  always_ff @(posedge axi_aclk) begin
    // First write lands in lanes 0..3
    if (fifo_wr_en && !phase) begin
      half_word <= fifo_din;
    end
    // Second write supplies lanes 4..7
    if (pair_done) begin
      push_word <= {fifo_din, half_word};
    end
  end

endmodule

/* replay_axis_pkg.sv */
// AXI-Stream field types and deframer state encoding
package replay_axis_pkg;

  // Stream field widths
  localparam int TDATA_BITS = 64;
  localparam int TSTRB_BITS = TDATA_BITS / 8;
  localparam int TUSER_BITS = 32;

  // 64-bit beat payload
  typedef logic [TDATA_BITS-1:0] tdata_t;

  // One strobe bit per byte lane
  typedef logic [TSTRB_BITS-1:0] tstrb_t;

  // Per-packet metadata taken from the header word
  typedef logic [TUSER_BITS-1:0] tuser_t;

  // Deframer FSM
  // st_header waits for and consumes the header word
  // st_packet streams beats until a partial strobe
  typedef enum logic {
    st_header,
    st_packet
  } deframer_state_t;

endpackage

/* replay_cfg_pkg.sv */
// Lane layout, host write word and packed word types, FIFO sizing defaults
package replay_cfg_pkg;

  // One lane is a strobe bit sitting above one data byte
  localparam int LANE_BITS = 9;

  // Data bits inside a lane
  localparam int BYTE_BITS = LANE_BITS - 1;

  // Host side write word, four lanes
  localparam int WR_LANES = 4;

  // Buffered word, two write words side by side
  localparam int RD_LANES = 8;

  // Derived widths
  localparam int WR_BITS = WR_LANES * LANE_BITS;
  localparam int RD_BITS = RD_LANES * LANE_BITS;

  // 36-bit host write word
  typedef logic [WR_BITS-1:0] wr_word_t;

  // 72-bit packed word as held in the FIFO
  // Lane i occupies bits [9i+8:9i], strobe on top
  typedef logic [RD_BITS-1:0] packed_word_t;

  // Default FIFO depth in packed words, power of two
  localparam int FIFO_DEPTH_DEFAULT = 16;

  // Default almost-full threshold in packed words
  localparam int PROG_FULL_DEFAULT = 12;

endpackage
